// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cu_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== ctrl_issue.sv ====
module ctrl_issue (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cu_pkg::ILEN-1:0]       inst,
    input  logic [cu_pkg::XLEN-1:0]       imm,
    input  cu_pkg::cmp_res_e              cmp_out,
    dec_if.iss                            dec,
    output logic                          out_valid,
    output logic [cu_pkg::REG_ADDR_W-1:0] rs1,
    output logic [cu_pkg::REG_ADDR_W-1:0] rs2,
    output logic [cu_pkg::REG_ADDR_W-1:0] rd,
    output logic [cu_pkg::XLEN-1:0]       imm_q,
    output cu_pkg::ctrl_t                 ctrl_q,
    output logic                          illegal_q,
    output logic                          ebreak_q
);

    cu_pkg::ctrl_t ctrl_d;
    logic          taken;

    always_comb begin
        ctrl_d = dec.ctrl;
        taken  = 1'b0;
        case (dec.cond)
            cu_pkg::COND_SET_LT: begin
                ctrl_d.sel_regs = (cmp_out == cu_pkg::CMP_LT) ? cu_pkg::REG_ONE : cu_pkg::REG_ZERO;
            end
            cu_pkg::COND_BR_EQ: taken = (cmp_out == cu_pkg::CMP_EQ);
            cu_pkg::COND_BR_NE: taken = (cmp_out != cu_pkg::CMP_EQ);
            cu_pkg::COND_BR_GE: taken = (cmp_out == cu_pkg::CMP_EQ) || (cmp_out == cu_pkg::CMP_GT);
            cu_pkg::COND_BR_LT: taken = (cmp_out == cu_pkg::CMP_LT);
            default: ;
        endcase
        if (taken) begin
            ctrl_d.sel_pc = cu_pkg::PC_ALU; // branch target from alu
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            illegal_q <= 1'b0;
            ebreak_q  <= 1'b0;
            ctrl_q    <= '0;
        end else begin
            out_valid <= dec.valid;
            if (dec.valid) begin
                illegal_q <= dec.illegal;
                ebreak_q  <= dec.ebreak;
                ctrl_q    <= ctrl_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            rs1   <= inst[19:15];
            rs2   <= inst[24:20];
            rd    <= inst[11:7];
            imm_q <= imm;
        end
    end

    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dec.illegal && dec.ebreak));

    // a branch issued last cycle never carries a memory op
    a_branch_no_mem: assert property (@(posedge clk) disable iff (rst)
        dec.valid && (dec.cond inside {cu_pkg::COND_BR_EQ, cu_pkg::COND_BR_NE,
                                       cu_pkg::COND_BR_GE, cu_pkg::COND_BR_LT})
        |=> ctrl_q.ctrl_mem == cu_pkg::MEM_NONE);

    a_reset_invalid: assert property (@(posedge clk) rst |=> !out_valid);

endmodule

// ==== cu_pkg.sv ====
package cu_pkg;

    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam int ALU_OP_W  = 5;
    localparam int ALU_SRC_W = 3;
    localparam int CMP_SRC_W = 2;
    localparam int REG_SRC_W = 3;
    localparam int PC_SRC_W  = 2;
    localparam int MEM_OP_W  = 4;
    localparam int MEM_SEL_W = 3;
    localparam int CMP_RES_W = 2;
    localparam int IMM_FMT_W = 3;
    localparam int COND_W    = 3;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_REG_W  = 7'b0111011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_IMM_W  = 7'b0011011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [ILEN-1:0] INST_EBREAK = {12'h001, 5'd0, 3'd0, 5'd0, OP_SYSTEM};

    localparam logic [MEM_SEL_W-1:0] MEM_ADDR_ALU = 3'b001; // address from alu result
    localparam logic [MEM_SEL_W-1:0] MEM_DATA_RS2 = 3'b010; // store data from rs2

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_NONE  = 5'b00000, ALU_ADD   = 5'b00001, ALU_ADDC  = 5'b00010,
        ALU_SLL   = 5'b00011, ALU_ADDW  = 5'b00100, ALU_SUB   = 5'b00101,
        ALU_SRA   = 5'b00110, ALU_AND   = 5'b00111, ALU_SLLW  = 5'b01000,
        ALU_XOR   = 5'b01001, ALU_OR    = 5'b01010, ALU_SRL   = 5'b01011,
        ALU_SUBW  = 5'b11001, ALU_SLLIW = 5'b11010, ALU_SRAIW = 5'b11011
    } alu_op_e;

    typedef enum logic [ALU_SRC_W-1:0] {
        SRC_RS_RS  = 3'b000, SRC_RS_IMM  = 3'b001, SRC_RS_PC = 3'b010,
        SRC_RS_SNPC = 3'b011, SRC_IMM_PC = 3'b100, SRC_IMM_SNPC = 3'b101
    } alu_src_e;

    typedef enum logic [CMP_SRC_W-1:0] {
        CMP_RS2 = 2'b00,
        CMP_IMM = 2'b01
    } cmp_src_e;

    typedef enum logic [REG_SRC_W-1:0] {
        REG_NONE = 3'b000, REG_ALU  = 3'b001, REG_PC  = 3'b010, REG_SNPC = 3'b011,
        REG_IMM  = 3'b100, REG_MEM  = 3'b101, REG_ZERO = 3'b110, REG_ONE = 3'b111
    } reg_src_e;

    typedef enum logic [PC_SRC_W-1:0] {
        PC_SNPC = 2'b00,
        PC_ALU  = 2'b01
    } pc_src_e;

    typedef enum logic [MEM_OP_W-1:0] {
        MEM_NONE = 4'b0000, MEM_LD  = 4'b0001, MEM_LW = 4'b0010, MEM_LH = 4'b0011,
        MEM_LHU  = 4'b0110, MEM_LBU = 4'b0111, MEM_SD = 4'b1000, MEM_SW = 4'b1001,
        MEM_SH   = 4'b1010, MEM_SB  = 4'b1011
    } mem_op_e;

    typedef enum logic [CMP_RES_W-1:0] {
        CMP_EQ = 2'b00,
        CMP_LT = 2'b01,
        CMP_GT = 2'b10
    } cmp_res_e;

    typedef enum logic [IMM_FMT_W-1:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

    typedef enum logic [COND_W-1:0] {
        COND_NONE, COND_SET_LT, COND_BR_EQ, COND_BR_NE, COND_BR_GE, COND_BR_LT
    } cond_e;

    typedef struct packed {
        alu_op_e               ctrl_alu;
        alu_src_e              sel_alu;
        logic                  ctrl_cmp;     // signed compare
        cmp_src_e              sel_cmp;
        reg_src_e              sel_regs;
        pc_src_e               sel_pc;
        mem_op_e               ctrl_mem;
        logic [MEM_SEL_W-1:0]  sel_mem_addr;
        logic [MEM_SEL_W-1:0]  sel_mem_data;
    } ctrl_t;

endpackage

// ==== cu_top.sv ====
module cu_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          inst_valid,
    input  logic [cu_pkg::ILEN-1:0]       inst,
    input  logic [cu_pkg::CMP_RES_W-1:0]  cmp_out,
    output logic                          out_valid,
    output logic [cu_pkg::REG_ADDR_W-1:0] rs1,
    output logic [cu_pkg::REG_ADDR_W-1:0] rs2,
    output logic [cu_pkg::REG_ADDR_W-1:0] rd,
    output logic [cu_pkg::XLEN-1:0]       imm,
    output logic [cu_pkg::ALU_OP_W-1:0]   ctrl_alu,
    output logic [cu_pkg::ALU_SRC_W-1:0]  sel_alu,
    output logic                          ctrl_cmp,
    output logic [cu_pkg::CMP_SRC_W-1:0]  sel_cmp,
    output logic [cu_pkg::REG_SRC_W-1:0]  sel_regs,
    output logic [cu_pkg::PC_SRC_W-1:0]   sel_pc,
    output logic [cu_pkg::MEM_OP_W-1:0]   ctrl_mem,
    output logic [cu_pkg::MEM_SEL_W-1:0]  sel_mem_addr,
    output logic [cu_pkg::MEM_SEL_W-1:0]  sel_mem_data,
    output logic                          illegal,
    output logic                          ebreak
);

    dec_if                    dec_bus ();
    cu_pkg::imm_fmt_e         fmt;
    logic [cu_pkg::XLEN-1:0]  imm_d;
    cu_pkg::ctrl_t            ctrl_q;

    inst_decoder u_inst_decoder (
        .inst       (inst),
        .inst_valid (inst_valid),
        .fmt        (fmt),
        .dec        (dec_bus.dec)
    );

    imm_gen u_imm_gen (
        .inst (inst),
        .fmt  (fmt),
        .imm  (imm_d)
    );

    ctrl_issue u_ctrl_issue (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .imm       (imm_d),
        .cmp_out   (cu_pkg::cmp_res_e'(cmp_out)),
        .dec       (dec_bus.iss),
        .out_valid (out_valid),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm_q     (imm),
        .ctrl_q    (ctrl_q),
        .illegal_q (illegal),
        .ebreak_q  (ebreak)
    );

    // flatten the registered controls
    assign ctrl_alu     = ctrl_q.ctrl_alu;
    assign sel_alu      = ctrl_q.sel_alu;
    assign ctrl_cmp     = ctrl_q.ctrl_cmp;
    assign sel_cmp      = ctrl_q.sel_cmp;
    assign sel_regs     = ctrl_q.sel_regs;
    assign sel_pc       = ctrl_q.sel_pc;
    assign ctrl_mem     = ctrl_q.ctrl_mem;
    assign sel_mem_addr = ctrl_q.sel_mem_addr;
    assign sel_mem_data = ctrl_q.sel_mem_data;

endmodule

// ==== dec_if.sv ====
interface dec_if;

    logic          valid;
    cu_pkg::ctrl_t ctrl;
    cu_pkg::cond_e cond;     // compare-dependent select still to resolve
    logic          illegal;
    logic          ebreak;

    modport dec (
        output valid,
        output ctrl,
        output cond,
        output illegal,
        output ebreak
    );

    modport iss (
        input valid,
        input ctrl,
        input cond,
        input illegal,
        input ebreak
    );

endinterface

// ==== filelist.f ====
cu_pkg.sv
dec_if.sv
imm_gen.sv
inst_decoder.sv
ctrl_issue.sv
cu_top.sv
tb_cu_top.sv

// ==== imm_gen.sv ====
module imm_gen (
    input  logic [cu_pkg::ILEN-1:0] inst,
    input  cu_pkg::imm_fmt_e        fmt,
    output logic [cu_pkg::XLEN-1:0] imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (fmt)
            cu_pkg::IMM_I: begin
                imm = {{(cu_pkg::XLEN-12){sign}}, inst[31:20]};
            end
            cu_pkg::IMM_S: begin
                imm = {{(cu_pkg::XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            cu_pkg::IMM_B: begin // bit 0 always clear
                imm = {{(cu_pkg::XLEN-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            cu_pkg::IMM_U: begin
                imm = {{(cu_pkg::XLEN-32){sign}}, inst[31:12], 12'b0};
            end
            cu_pkg::IMM_J: begin
                imm = {{(cu_pkg::XLEN-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== inst_decoder.sv ====
module inst_decoder (
    input  logic [cu_pkg::ILEN-1:0] inst,
    input  logic                    inst_valid,
    output cu_pkg::imm_fmt_e        fmt,
    dec_if.dec                      dec
);

    cu_pkg::ctrl_t c;
    cu_pkg::cond_e cond;
    logic          hit;
    logic          brk;

    always_comb begin
        c    = '0;
        fmt  = cu_pkg::IMM_NONE;
        cond = cu_pkg::COND_NONE;
        hit  = 1'b1;
        brk  = 1'b0;

        // operand routing per opcode class
        case (inst[6:0])
            cu_pkg::OP_REG, cu_pkg::OP_REG_W: begin
                c.sel_regs = cu_pkg::REG_ALU;
            end
            cu_pkg::OP_IMM, cu_pkg::OP_IMM_W: begin
                c.sel_alu  = cu_pkg::SRC_RS_IMM;
                c.sel_regs = cu_pkg::REG_ALU;
                fmt        = cu_pkg::IMM_I;
            end
            cu_pkg::OP_LOAD: begin
                c.ctrl_alu     = cu_pkg::ALU_ADD;
                c.sel_alu      = cu_pkg::SRC_RS_IMM;
                c.sel_regs     = cu_pkg::REG_MEM;
                c.sel_mem_addr = cu_pkg::MEM_ADDR_ALU;
                fmt            = cu_pkg::IMM_I;
            end
            cu_pkg::OP_STORE: begin
                c.ctrl_alu     = cu_pkg::ALU_ADD;
                c.sel_alu      = cu_pkg::SRC_RS_IMM;
                c.sel_mem_addr = cu_pkg::MEM_ADDR_ALU;
                c.sel_mem_data = cu_pkg::MEM_DATA_RS2;
                fmt            = cu_pkg::IMM_S;
            end
            cu_pkg::OP_BRANCH: begin // target = pc + imm
                c.ctrl_alu = cu_pkg::ALU_ADD;
                c.sel_alu  = cu_pkg::SRC_IMM_PC;
                fmt        = cu_pkg::IMM_B;
            end
            cu_pkg::OP_JAL: begin
                c.ctrl_alu = cu_pkg::ALU_ADD;
                c.sel_alu  = cu_pkg::SRC_IMM_PC;
                c.sel_regs = cu_pkg::REG_SNPC;
                c.sel_pc   = cu_pkg::PC_ALU;
                fmt        = cu_pkg::IMM_J;
            end
            cu_pkg::OP_JALR: begin
                c.sel_alu  = cu_pkg::SRC_RS_IMM;
                c.sel_regs = cu_pkg::REG_SNPC;
                c.sel_pc   = cu_pkg::PC_ALU;
                fmt        = cu_pkg::IMM_I;
            end
            cu_pkg::OP_LUI: begin
                c.sel_regs = cu_pkg::REG_IMM;
                fmt        = cu_pkg::IMM_U;
            end
            cu_pkg::OP_AUIPC: begin
                c.ctrl_alu = cu_pkg::ALU_ADD;
                c.sel_alu  = cu_pkg::SRC_IMM_PC;
                c.sel_regs = cu_pkg::REG_ALU;
                fmt        = cu_pkg::IMM_U;
            end
            default: ;
        endcase

        // funct-level match, anything not listed is illegal
        casez (inst)
            32'b0000000_?????_?????_000_?????_0110011: c.ctrl_alu = cu_pkg::ALU_ADD;   // add
            32'b0000000_?????_?????_000_?????_0111011: c.ctrl_alu = cu_pkg::ALU_ADDW;  // addw
            32'b0100000_?????_?????_000_?????_0110011: c.ctrl_alu = cu_pkg::ALU_SUB;   // sub
            32'b0000000_?????_?????_001_?????_0111011: c.ctrl_alu = cu_pkg::ALU_SLLW;  // sllw
            32'b0000000_?????_?????_111_?????_0110011: c.ctrl_alu = cu_pkg::ALU_AND;   // and
            32'b0000000_?????_?????_110_?????_0110011: c.ctrl_alu = cu_pkg::ALU_OR;    // or
            32'b0100000_?????_?????_000_?????_0111011: c.ctrl_alu = cu_pkg::ALU_SUBW;  // subw
            32'b0000000_?????_?????_010_?????_0110011: begin                         // slt
                c.ctrl_cmp = 1'b1;
                cond       = cu_pkg::COND_SET_LT;
            end
            32'b0000000_?????_?????_011_?????_0110011: cond = cu_pkg::COND_SET_LT;     // sltu
            32'b???????_?????_?????_000_?????_0010011: c.ctrl_alu = cu_pkg::ALU_ADD;   // addi
            32'b???????_?????_?????_000_?????_1100111: c.ctrl_alu = cu_pkg::ALU_ADDC;  // jalr
            32'b000000?_?????_?????_001_?????_0010011: c.ctrl_alu = cu_pkg::ALU_SLL;   // slli
            32'b???????_?????_?????_010_?????_0000011: c.ctrl_mem = cu_pkg::MEM_LW;    // lw
            32'b???????_?????_?????_011_?????_0010011: begin                         // sltiu
                c.sel_alu = cu_pkg::SRC_RS_RS;
                c.sel_cmp = cu_pkg::CMP_IMM;
                cond      = cu_pkg::COND_SET_LT;
            end
            32'b???????_?????_?????_000_?????_0011011: c.ctrl_alu = cu_pkg::ALU_ADDW;  // addiw
            32'b???????_?????_?????_011_?????_0000011: c.ctrl_mem = cu_pkg::MEM_LD;    // ld
            32'b010000?_?????_?????_101_?????_0010011: c.ctrl_alu = cu_pkg::ALU_SRA;   // srai
            32'b???????_?????_?????_100_?????_0000011: c.ctrl_mem = cu_pkg::MEM_LBU;   // lbu
            32'b???????_?????_?????_111_?????_0010011: c.ctrl_alu = cu_pkg::ALU_AND;   // andi
            32'b???????_?????_?????_100_?????_0010011: c.ctrl_alu = cu_pkg::ALU_XOR;   // xori
            32'b???????_?????_?????_101_?????_0010011: c.ctrl_alu = cu_pkg::ALU_SRL;   // srli
            32'b???????_?????_?????_001_?????_0000011: c.ctrl_mem = cu_pkg::MEM_LH;    // lh
            32'b???????_?????_?????_101_?????_0000011: c.ctrl_mem = cu_pkg::MEM_LHU;   // lhu
            32'b000000?_?????_?????_001_?????_0011011: c.ctrl_alu = cu_pkg::ALU_SLLIW; // slliw
            32'b010000?_?????_?????_101_?????_0011011: c.ctrl_alu = cu_pkg::ALU_SRAIW; // sraiw
            32'b???????_?????_?????_011_?????_0100011: c.ctrl_mem = cu_pkg::MEM_SD;    // sd
            32'b???????_?????_?????_001_?????_0100011: c.ctrl_mem = cu_pkg::MEM_SH;    // sh
            32'b???????_?????_?????_000_?????_0100011: c.ctrl_mem = cu_pkg::MEM_SB;    // sb
            32'b???????_?????_?????_010_?????_0100011: c.ctrl_mem = cu_pkg::MEM_SW;    // sw
            32'b???????_?????_?????_000_?????_1100011: cond = cu_pkg::COND_BR_EQ;      // beq
            32'b???????_?????_?????_001_?????_1100011: cond = cu_pkg::COND_BR_NE;      // bne
            32'b???????_?????_?????_101_?????_1100011: begin                         // bge
                c.ctrl_cmp = 1'b1;
                cond       = cu_pkg::COND_BR_GE;
            end
            32'b???????_?????_?????_111_?????_1100011: cond = cu_pkg::COND_BR_GE;      // bgeu
            32'b???????_?????_?????_110_?????_1100011: cond = cu_pkg::COND_BR_LT;      // bltu
            32'b???????_?????_?????_100_?????_1100011: begin                         // blt
                c.ctrl_cmp = 1'b1;
                cond       = cu_pkg::COND_BR_LT;
            end
            32'b???????_?????_?????_???_?????_0010111,                                // auipc
            32'b???????_?????_?????_???_?????_0110111,                                // lui
            32'b???????_?????_?????_???_?????_1101111: ;                              // jal
            cu_pkg::INST_EBREAK: brk = 1'b1;
            default: hit = 1'b0;
        endcase

        if (!hit) begin // no partial controls from the opcode class
            c    = '0;
            fmt  = cu_pkg::IMM_NONE;
            cond = cu_pkg::COND_NONE;
        end
    end

    assign dec.valid   = inst_valid;
    assign dec.ctrl    = c;
    assign dec.cond    = cond;
    assign dec.illegal = inst_valid & ~hit;
    assign dec.ebreak  = inst_valid & brk;

endmodule

// ==== tb_cu_top.sv ====
module tb_cu_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 20;
    localparam int N_TESTS         = 6;
    localparam int CYCLES_PER_TEST = 120;
    localparam int MARGIN_CYCLES   = 100;
    localparam int TIMEOUT_NS      = (N_TESTS * CYCLES_PER_TEST + MARGIN_CYCLES) * CLK_PERIOD;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          inst_valid;
    logic [cu_pkg::ILEN-1:0]       inst;
    logic [cu_pkg::CMP_RES_W-1:0]  cmp_out;
    logic                          out_valid;
    logic [cu_pkg::REG_ADDR_W-1:0] rs1;
    logic [cu_pkg::REG_ADDR_W-1:0] rs2;
    logic [cu_pkg::REG_ADDR_W-1:0] rd;
    logic [cu_pkg::XLEN-1:0]       imm;
    logic [cu_pkg::ALU_OP_W-1:0]   ctrl_alu;
    logic [cu_pkg::ALU_SRC_W-1:0]  sel_alu;
    logic                          ctrl_cmp;
    logic [cu_pkg::CMP_SRC_W-1:0]  sel_cmp;
    logic [cu_pkg::REG_SRC_W-1:0]  sel_regs;
    logic [cu_pkg::PC_SRC_W-1:0]   sel_pc;
    logic [cu_pkg::MEM_OP_W-1:0]   ctrl_mem;
    logic [cu_pkg::MEM_SEL_W-1:0]  sel_mem_addr;
    logic [cu_pkg::MEM_SEL_W-1:0]  sel_mem_data;
    logic                          illegal;
    logic                          ebreak;
    logic [31:0]                   lcg_state = 32'd37;
    int                            errors = 0;

    cu_top u_cu_top (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [1:0] cmp);
        case (f3)
            3'b000:         return cmp == cu_pkg::CMP_EQ; // beq
            3'b001:         return cmp != cu_pkg::CMP_EQ; // bne
            3'b100, 3'b110: return cmp == cu_pkg::CMP_LT; // blt, bltu
            default:        return (cmp == cu_pkg::CMP_EQ) || (cmp == cu_pkg::CMP_GT);
        endcase
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // drives one instruction and samples its result mid-cycle
    task automatic issue(input logic [31:0] word, input logic [1:0] cmp);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= word;
        cmp_out    <= cmp;
        @(posedge clk);
        @(negedge clk);
        check(out_valid, 1'b1, "out_valid");
    endtask

    task automatic check_ctrl(input string name, input logic [4:0] alu, input logic [2:0] src,
                              input logic cmp_signed, input logic [1:0] cmp_sel,
                              input logic [2:0] regs, input logic [1:0] pc,
                              input logic [3:0] mem, input logic [2:0] maddr,
                              input logic [2:0] mdata);
        check(ctrl_alu, alu, {name, " ctrl_alu"});
        check(sel_alu, src, {name, " sel_alu"});
        check(ctrl_cmp, cmp_signed, {name, " ctrl_cmp"});
        check(sel_cmp, cmp_sel, {name, " sel_cmp"});
        check(sel_regs, regs, {name, " sel_regs"});
        check(sel_pc, pc, {name, " sel_pc"});
        check(ctrl_mem, mem, {name, " ctrl_mem"});
        check(sel_mem_addr, maddr, {name, " sel_mem_addr"});
        check(sel_mem_data, mdata, {name, " sel_mem_data"});
        check({illegal, ebreak}, 2'b00, {name, " flags"});
    endtask

    task automatic alu_row(input string name, input logic [6:0] f7, input logic [2:0] f3,
                           input logic [6:0] op, input logic shift, input logic [4:0] alu);
        logic [31:0] r;
        logic [11:0] imm12;
        logic        reg_form;
        r        = lcg_next();
        reg_form = (op == cu_pkg::OP_REG) || (op == cu_pkg::OP_REG_W);
        imm12    = shift ? {f7[6:1], r[25:20]} : r[31:20]; // shamt below funct6
        if (reg_form) begin
            issue({f7, r[24:20], r[19:15], f3, r[11:7], op}, 2'b00);
            check(rs2, r[24:20], {name, " rs2"});
        end else begin
            issue({imm12, r[19:15], f3, r[11:7], op}, 2'b00);
            check(imm, {{52{imm12[11]}}, imm12}, {name, " imm"});
        end
        check(rs1, r[19:15], {name, " rs1"});
        check(rd, r[11:7], {name, " rd"});
        check_ctrl(name, alu, reg_form ? cu_pkg::SRC_RS_RS : cu_pkg::SRC_RS_IMM, 1'b0,
                   cu_pkg::CMP_RS2, cu_pkg::REG_ALU, cu_pkg::PC_SNPC, cu_pkg::MEM_NONE,
                   3'b000, 3'b000);
    endtask

    task automatic mem_row(input string name, input logic [2:0] f3, input logic store,
                           input logic [3:0] mem);
        logic [31:0] r;
        r = lcg_next();
        if (store) begin
            issue({r[31:25], r[24:20], r[19:15], f3, r[11:7], cu_pkg::OP_STORE}, 2'b00);
            check(imm, {{52{r[31]}}, r[31:25], r[11:7]}, {name, " imm"});
            check(rs2, r[24:20], {name, " rs2"});
            check_ctrl(name, cu_pkg::ALU_ADD, cu_pkg::SRC_RS_IMM, 1'b0, cu_pkg::CMP_RS2,
                       cu_pkg::REG_NONE, cu_pkg::PC_SNPC, mem, 3'b001, 3'b010);
        end else begin
            issue({r[31:20], r[19:15], f3, r[11:7], cu_pkg::OP_LOAD}, 2'b00);
            check(imm, {{52{r[31]}}, r[31:20]}, {name, " imm"});
            check(rd, r[11:7], {name, " rd"});
            check_ctrl(name, cu_pkg::ALU_ADD, cu_pkg::SRC_RS_IMM, 1'b0, cu_pkg::CMP_RS2,
                       cu_pkg::REG_MEM, cu_pkg::PC_SNPC, mem, 3'b001, 3'b000);
        end
        check(rs1, r[19:15], {name, " rs1"});
    endtask

    task automatic upper_row(input string name, input logic [6:0] op);
        logic [31:0] r;
        r = lcg_next();
        issue({r[31:12], r[11:7], op}, 2'b00);
        check(imm, {{32{r[31]}}, r[31:12], 12'h000}, {name, " imm"});
        check(rd, r[11:7], {name, " rd"});
        if (op == cu_pkg::OP_LUI) begin
            check_ctrl(name, cu_pkg::ALU_NONE, cu_pkg::SRC_RS_RS, 1'b0, cu_pkg::CMP_RS2,
                       cu_pkg::REG_IMM, cu_pkg::PC_SNPC, cu_pkg::MEM_NONE, 3'b000, 3'b000);
        end else begin
            check_ctrl(name, cu_pkg::ALU_ADD, cu_pkg::SRC_IMM_PC, 1'b0, cu_pkg::CMP_RS2,
                       cu_pkg::REG_ALU, cu_pkg::PC_SNPC, cu_pkg::MEM_NONE, 3'b000, 3'b000);
        end
    endtask

    task automatic branch_row(input string name, input logic [2:0] f3, input logic cmp_signed);
        logic [31:0] r;
        logic [12:0] b;
        for (int c = 0; c < 3; c++) begin
            r = lcg_next();
            b = {r[11:0], 1'b0};
            issue({b[12], b[10:5], r[24:20], r[19:15], f3, b[4:1], b[11], cu_pkg::OP_BRANCH},
                  2'(c));
            check(imm, {{51{b[12]}}, b}, {name, " imm"});
            check({rs1, rs2}, {r[19:15], r[24:20]}, {name, " rs1/rs2"});
            check_ctrl(name, cu_pkg::ALU_ADD, cu_pkg::SRC_IMM_PC, cmp_signed, cu_pkg::CMP_RS2,
                       cu_pkg::REG_NONE,
                       branch_taken(f3, 2'(c)) ? cu_pkg::PC_ALU : cu_pkg::PC_SNPC,
                       cu_pkg::MEM_NONE, 3'b000, 3'b000);
        end
    endtask

    task automatic slt_row(input string name, input logic [31:0] word, input logic cmp_signed,
                           input logic [1:0] cmp_sel);
        for (int c = 0; c < 3; c++) begin
            issue(word, 2'(c));
            check_ctrl(name, cu_pkg::ALU_NONE, cu_pkg::SRC_RS_RS, cmp_signed, cmp_sel,
                       (2'(c) == cu_pkg::CMP_LT) ? cu_pkg::REG_ONE : cu_pkg::REG_ZERO,
                       cu_pkg::PC_SNPC, cu_pkg::MEM_NONE, 3'b000, 3'b000);
        end
    endtask

    task automatic illegal_row(input string name, input logic [2:0] f3);
        logic [31:0] r;
        r = lcg_next();
        issue({7'b0000001, r[24:20], r[19:15], f3, r[11:7], cu_pkg::OP_REG_W}, 2'b00);
        check({illegal, ebreak}, 2'b10, {name, " flags"});
        check({ctrl_alu, sel_alu, ctrl_cmp, sel_cmp, sel_regs, sel_pc, ctrl_mem,
               sel_mem_addr, sel_mem_data}, '0, {name, " controls"});
    endtask

    task automatic reset_and_idle();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check({out_valid, illegal, ebreak}, 3'b000, "valid and flags after reset");
        check({ctrl_mem, sel_regs, sel_pc}, '0, "mem, regs and pc selects after reset");
        @(posedge clk);
        inst_valid <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check(out_valid, 1'b0, "out_valid with inst_valid low");
    endtask

    task automatic alu_decode();
        alu_row("add", 7'b0000000, 3'b000, cu_pkg::OP_REG, 1'b0, cu_pkg::ALU_ADD);
        alu_row("addw", 7'b0000000, 3'b000, cu_pkg::OP_REG_W, 1'b0, cu_pkg::ALU_ADDW);
        alu_row("sub", 7'b0100000, 3'b000, cu_pkg::OP_REG, 1'b0, cu_pkg::ALU_SUB);
        alu_row("sllw", 7'b0000000, 3'b001, cu_pkg::OP_REG_W, 1'b0, cu_pkg::ALU_SLLW);
        alu_row("and", 7'b0000000, 3'b111, cu_pkg::OP_REG, 1'b0, cu_pkg::ALU_AND);
        alu_row("or", 7'b0000000, 3'b110, cu_pkg::OP_REG, 1'b0, cu_pkg::ALU_OR);
        alu_row("subw", 7'b0100000, 3'b000, cu_pkg::OP_REG_W, 1'b0, cu_pkg::ALU_SUBW);
        alu_row("addi", 7'b0000000, 3'b000, cu_pkg::OP_IMM, 1'b0, cu_pkg::ALU_ADD);
        alu_row("slli", 7'b0000000, 3'b001, cu_pkg::OP_IMM, 1'b1, cu_pkg::ALU_SLL);
        alu_row("addiw", 7'b0000000, 3'b000, cu_pkg::OP_IMM_W, 1'b0, cu_pkg::ALU_ADDW);
        alu_row("srai", 7'b0100000, 3'b101, cu_pkg::OP_IMM, 1'b1, cu_pkg::ALU_SRA);
        alu_row("andi", 7'b0000000, 3'b111, cu_pkg::OP_IMM, 1'b0, cu_pkg::ALU_AND);
        alu_row("xori", 7'b0000000, 3'b100, cu_pkg::OP_IMM, 1'b0, cu_pkg::ALU_XOR);
        alu_row("srli", 7'b0000000, 3'b101, cu_pkg::OP_IMM, 1'b1, cu_pkg::ALU_SRL);
        alu_row("slliw", 7'b0000000, 3'b001, cu_pkg::OP_IMM_W, 1'b1, cu_pkg::ALU_SLLIW);
        alu_row("sraiw", 7'b0100000, 3'b101, cu_pkg::OP_IMM_W, 1'b1, cu_pkg::ALU_SRAIW);
    endtask

    task automatic immediate_formats();
        repeat (3) begin
            mem_row("sd", 3'b011, 1'b1, cu_pkg::MEM_SD);
            mem_row("sh", 3'b001, 1'b1, cu_pkg::MEM_SH);
            mem_row("sb", 3'b000, 1'b1, cu_pkg::MEM_SB);
            mem_row("sw", 3'b010, 1'b1, cu_pkg::MEM_SW);
            mem_row("ld", 3'b011, 1'b0, cu_pkg::MEM_LD);
            mem_row("lw", 3'b010, 1'b0, cu_pkg::MEM_LW);
            mem_row("lh", 3'b001, 1'b0, cu_pkg::MEM_LH);
            mem_row("lhu", 3'b101, 1'b0, cu_pkg::MEM_LHU);
            mem_row("lbu", 3'b100, 1'b0, cu_pkg::MEM_LBU);
            upper_row("lui", cu_pkg::OP_LUI);
            upper_row("auipc", cu_pkg::OP_AUIPC);
        end
    endtask

    task automatic branch_resolution();
        branch_row("beq", 3'b000, 1'b0);
        branch_row("bne", 3'b001, 1'b0);
        branch_row("bge", 3'b101, 1'b1);
        branch_row("bgeu", 3'b111, 1'b0);
        branch_row("bltu", 3'b110, 1'b0);
        branch_row("blt", 3'b100, 1'b1);
    endtask

    task automatic slt_and_jumps();
        logic [31:0] r;
        logic [20:0] j;
        r = lcg_next();
        slt_row("slt", {7'b0, r[24:20], r[19:15], 3'b010, r[11:7], cu_pkg::OP_REG}, 1'b1,
                cu_pkg::CMP_RS2);
        slt_row("sltu", {7'b0, r[24:20], r[19:15], 3'b011, r[11:7], cu_pkg::OP_REG}, 1'b0,
                cu_pkg::CMP_RS2);
        slt_row("sltiu", {r[31:20], r[19:15], 3'b011, r[11:7], cu_pkg::OP_IMM}, 1'b0,
                cu_pkg::CMP_IMM);
        j = {r[31:12], 1'b0};
        issue({j[20], j[10:1], j[11], j[19:12], r[11:7], cu_pkg::OP_JAL}, 2'b00);
        check(imm, {{43{j[20]}}, j}, "jal imm");
        check(rd, r[11:7], "jal rd");
        check_ctrl("jal", cu_pkg::ALU_ADD, cu_pkg::SRC_IMM_PC, 1'b0, cu_pkg::CMP_RS2,
                   cu_pkg::REG_SNPC, cu_pkg::PC_ALU, cu_pkg::MEM_NONE, 3'b000, 3'b000);
        r = lcg_next();
        issue({r[31:20], r[19:15], 3'b000, r[11:7], cu_pkg::OP_JALR}, 2'b00);
        check(imm, {{52{r[31]}}, r[31:20]}, "jalr imm");
        check_ctrl("jalr", cu_pkg::ALU_ADDC, cu_pkg::SRC_RS_IMM, 1'b0, cu_pkg::CMP_RS2,
                   cu_pkg::REG_SNPC, cu_pkg::PC_ALU, cu_pkg::MEM_NONE, 3'b000, 3'b000);
    endtask

    task automatic illegal_and_stream();
        logic [31:0] r;
        logic [11:0] exp_imm[$];
        illegal_row("mulw", 3'b000);
        illegal_row("divw", 3'b100);
        illegal_row("remw", 3'b110);
        issue(cu_pkg::INST_EBREAK, 2'b00);
        check({illegal, ebreak}, 2'b01, "ebreak flags");
        check({ctrl_alu, sel_alu, ctrl_cmp, sel_cmp, sel_regs, sel_pc, ctrl_mem,
               sel_mem_addr, sel_mem_data}, '0, "ebreak controls");
        // addi stream with rd tagging each slot
        for (int i = 0; i <= 6; i++) begin
            @(posedge clk);
            if (i < 6) begin
                r = lcg_next();
                inst_valid <= 1'b1;
                inst       <= {r[31:20], 5'd1, 3'b000, 5'(i + 1), cu_pkg::OP_IMM};
                exp_imm.push_back(r[31:20]);
            end else begin
                inst_valid <= 1'b0;
                inst       <= '0; // rd 0 must not reach the output
            end
            @(negedge clk);
            if (i > 0) begin
                check(out_valid, 1'b1, "stream out_valid");
                check(rd, 5'(i), "stream rd order");
                check(imm[11:0], exp_imm.pop_front(), "stream imm");
            end
        end
        @(posedge clk);
        @(negedge clk);
        check(out_valid, 1'b0, "out_valid after stream");
        check(rd, 5'd6, "rd held while idle");
    endtask

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        cmp_out    = '0;
        reset_and_idle();
        alu_decode();
        immediate_formats();
        branch_resolution();
        slt_and_jumps();
        illegal_and_stream();
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $fatal(1, "simulation timed out");
    end

endmodule
